/* arm_consts.svh */
`ifndef ARM_CONSTS_SVH
`define ARM_CONSTS_SVH

// Instruction class in bits 27:26
`define ARM_OP_DP   2'b00
`define ARM_OP_MEM  2'b01
`define ARM_OP_BR   2'b10

`define ARM_COND_AL 4'b1110  // Always
`define ARM_PC_REG  4'd15    // r15 is the PC

// Data-processing opcodes, bits 24:21
`define ARM_OPC_AND 4'b0000
`define ARM_OPC_EOR 4'b0001
`define ARM_OPC_SUB 4'b0010
`define ARM_OPC_RSB 4'b0011
`define ARM_OPC_ADD 4'b0100
`define ARM_OPC_ADC 4'b0101
`define ARM_OPC_SBC 4'b0110
`define ARM_OPC_RSC 4'b0111
`define ARM_OPC_TST 4'b1000
`define ARM_OPC_TEQ 4'b1001
`define ARM_OPC_CMP 4'b1010
`define ARM_OPC_CMN 4'b1011
`define ARM_OPC_ORR 4'b1100
`define ARM_OPC_MOV 4'b1101
`define ARM_OPC_BIC 4'b1110
`define ARM_OPC_MVN 4'b1111

`endif

/* verilog/armCtrlPkg.sv */
package armCtrlPkg;

  typedef logic [31:0] instrWord;
  typedef logic [31:0] dataWord;
  typedef logic [3:0]  regNum;
  typedef logic [3:0]  condCode;
  typedef logic [3:0]  aluCtrl;

  // Same bit order as the CPSR top nibble
  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } nzcvFlags;

  typedef struct packed {
    logic       aluSrc;      // Immediate operand B
    aluCtrl     aluControl;
    logic [1:0] flagWrite;   // [1] NZ enable, [0] CV enable
    logic       branch;
    logic       memWrite;
    logic       regWrite;
    logic       memtoReg;
    logic       pcSrc;       // Instruction writes the PC
    condCode    cond;
  } decodeCtrl;

  // Registers read and written by the D instruction
  typedef struct packed {
    regNum rn;
    regNum rm;
    regNum rd;
  } regUse;

  typedef struct packed {
    logic regWrite;
    logic memtoReg;
    logic pcSrc;
  } wbCtrl;

endpackage

/* verilog/instrDecoder.sv */
`timescale 1ns/10ps
`include "arm_consts.svh"

module instrDecoder (
  input  logic                  clk,
  input  logic                  reset,
  input  armCtrlPkg::instrWord  instrF,
  input  logic                  stallD,
  input  logic                  flushD,
  output armCtrlPkg::decodeCtrl ctrlD,
  output armCtrlPkg::regUse     regsD,
  output armCtrlPkg::dataWord   immD,
  output logic [1:0]            immSrcD,
  output logic [1:0]            regSrcD
);

  armCtrlPkg::instrWord instrD;
  armCtrlPkg::aluCtrl   opcodeD;
  logic [9:0] controlsD;
  logic aluSrcD, memtoRegD, regWriteD, memWriteD, branchD, aluOpD;
  logic isNopD, arithD;

  // Flush wins over stall
  always_ff @(posedge clk) begin
    if (reset || flushD) begin
      instrD <= '0;
    end else if (!stallD) begin
      instrD <= instrF;
    end
  end

  // All-zero word is ANDEQ r0,r0,r0 and serves as the bubble
  assign isNopD  = (instrD == '0);
  assign opcodeD = instrD[24:21];

  // regSrc, immSrc, aluSrc, memtoReg, regWrite, memWrite, branch, aluOp
  always_comb begin
    controlsD = '0;
    if (!isNopD) begin
      case (instrD[27:26])
        `ARM_OP_DP:  controlsD = instrD[25] ? 10'b00_00_101001 : 10'b00_00_001001;
        `ARM_OP_MEM: controlsD = instrD[20] ? 10'b00_01_111000 : 10'b10_01_100100; // LDR : STR
        `ARM_OP_BR:  controlsD = 10'b01_10_100010;
        default:     controlsD = '0;  // Class 11 not implemented
      endcase
    end
  end

  assign {regSrcD, immSrcD, aluSrcD, memtoRegD,
          regWriteD, memWriteD, branchD, aluOpD} = controlsD;

  always_comb begin
    case (opcodeD)
      `ARM_OPC_SUB, `ARM_OPC_RSB, `ARM_OPC_ADD, `ARM_OPC_ADC,
      `ARM_OPC_SBC, `ARM_OPC_RSC, `ARM_OPC_CMP, `ARM_OPC_CMN: arithD = 1'b1;
      default: arithD = 1'b0;
    endcase
  end

  always_comb begin
    ctrlD.aluSrc     = aluSrcD;
    ctrlD.aluControl = aluOpD ? opcodeD : `ARM_OPC_ADD;  // Address add otherwise
    ctrlD.flagWrite  = aluOpD ? {instrD[20], instrD[20] & arithD} : 2'b00;
    ctrlD.branch     = branchD;
    ctrlD.memWrite   = memWriteD;
    ctrlD.regWrite   = regWriteD;
    ctrlD.memtoReg   = memtoRegD;
    ctrlD.pcSrc      = branchD | (regWriteD & (instrD[15:12] == `ARM_PC_REG));
    ctrlD.cond       = instrD[31:28];
  end

  always_comb begin
    case (immSrcD)
      2'b00:   immD = {24'b0, instrD[7:0]};
      2'b01:   immD = {20'b0, instrD[11:0]};                   // LDR/STR offset
      2'b10:   immD = {{6{instrD[23]}}, instrD[23:0], 2'b00};  // Branch word offset
      default: immD = '0;
    endcase
  end

  // Branch reads the PC as rn, STR reads rd as store data
  // Immediate forms report the PC as rm so their immediate bits never match
  assign regsD.rn = regSrcD[0] ? `ARM_PC_REG : instrD[19:16];
  assign regsD.rm = regSrcD[1] ? instrD[15:12] :
                    (aluSrcD ? `ARM_PC_REG : instrD[3:0]);
  assign regsD.rd = instrD[15:12];

endmodule

/* verilog/condUnit.sv */
`timescale 1ns/10ps
`include "arm_consts.svh"

module condUnit (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 stallE,
  input  armCtrlPkg::condCode  cond,
  input  logic [1:0]           flagWrite,
  input  armCtrlPkg::nzcvFlags aluFlags,
  output logic                 condEx,
  output armCtrlPkg::nzcvFlags flags
);

  armCtrlPkg::nzcvFlags flagsNext;
  logic ge;

  assign ge = (flags.n == flags.v);

  always_comb begin
    case (cond)
      4'b0000:      condEx = flags.z;               // EQ
      4'b0001:      condEx = ~flags.z;              // NE
      4'b0010:      condEx = flags.c;               // CS
      4'b0011:      condEx = ~flags.c;              // CC
      4'b0100:      condEx = flags.n;               // MI
      4'b0101:      condEx = ~flags.n;              // PL
      4'b0110:      condEx = flags.v;               // VS
      4'b0111:      condEx = ~flags.v;              // VC
      4'b1000:      condEx = flags.c & ~flags.z;    // HI
      4'b1001:      condEx = ~flags.c | flags.z;    // LS
      4'b1010:      condEx = ge;                    // GE
      4'b1011:      condEx = ~ge;                   // LT
      4'b1100:      condEx = ~flags.z & ge;         // GT
      4'b1101:      condEx = flags.z | ~ge;         // LE
      `ARM_COND_AL: condEx = 1'b1;
      default:      condEx = 1'b0;                  // 1111 never executes
    endcase
  end

  // NZ and CV update independently
  assign {flagsNext.n, flagsNext.z} = (flagWrite[1] & condEx) ?
                                      {aluFlags.n, aluFlags.z} : {flags.n, flags.z};
  assign {flagsNext.c, flagsNext.v} = (flagWrite[0] & condEx) ?
                                      {aluFlags.c, aluFlags.v} : {flags.c, flags.v};

  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= '0;
    end else if (!stallE) begin
      flags <= flagsNext;
    end
  end

endmodule

/* verilog/aluCore.sv */
`timescale 1ns/10ps
`include "arm_consts.svh"

module aluCore (
  input  armCtrlPkg::dataWord  srcA,
  input  armCtrlPkg::dataWord  srcB,
  input  armCtrlPkg::aluCtrl   aluControl,
  input  logic                 carryIn,
  output armCtrlPkg::dataWord  result,
  output armCtrlPkg::nzcvFlags aluFlags
);

  armCtrlPkg::dataWord addA, addB, logicRes;
  logic [32:0] sum;
  logic addCin, isArith, overflow;

  // One adder for all arithmetic ops, operands swapped or inverted per opcode
  always_comb begin
    addA     = srcA;
    addB     = srcB;
    addCin   = 1'b0;
    isArith  = 1'b1;
    logicRes = '0;
    case (aluControl)
      `ARM_OPC_AND, `ARM_OPC_TST: begin
        isArith  = 1'b0;
        logicRes = srcA & srcB;
      end
      `ARM_OPC_EOR, `ARM_OPC_TEQ: begin
        isArith  = 1'b0;
        logicRes = srcA ^ srcB;
      end
      `ARM_OPC_SUB, `ARM_OPC_CMP: begin
        addB   = ~srcB;
        addCin = 1'b1;
      end
      `ARM_OPC_RSB: begin
        addA   = srcB;
        addB   = ~srcA;
        addCin = 1'b1;
      end
      `ARM_OPC_ADD, `ARM_OPC_CMN: addCin = 1'b0;
      `ARM_OPC_ADC: addCin = carryIn;
      `ARM_OPC_SBC: begin
        addB   = ~srcB;
        addCin = carryIn;  // Borrow is the inverted carry
      end
      `ARM_OPC_RSC: begin
        addA   = srcB;
        addB   = ~srcA;
        addCin = carryIn;
      end
      `ARM_OPC_ORR: begin
        isArith  = 1'b0;
        logicRes = srcA | srcB;
      end
      `ARM_OPC_MOV: begin
        isArith  = 1'b0;
        logicRes = srcB;
      end
      `ARM_OPC_BIC: begin
        isArith  = 1'b0;
        logicRes = srcA & ~srcB;
      end
      `ARM_OPC_MVN: begin
        isArith  = 1'b0;
        logicRes = ~srcB;
      end
    endcase
  end

  assign sum      = {1'b0, addA} + {1'b0, addB} + {32'b0, addCin};
  assign overflow = (addA[31] == addB[31]) & (sum[31] != addA[31]);
  assign result   = isArith ? sum[31:0] : logicRes;

  assign aluFlags.n = result[31];
  assign aluFlags.z = (result == '0);
  assign aluFlags.c = isArith ? sum[32] : carryIn;  // No shifter carry, keep C
  assign aluFlags.v = isArith & overflow;

endmodule

/* verilog/ctrlPipeline.sv */
`timescale 1ns/10ps
`include "arm_consts.svh"

module ctrlPipeline (
  input  logic                  clk,
  input  logic                  reset,
  input  armCtrlPkg::decodeCtrl ctrlD,
  input  armCtrlPkg::regUse     regsD,
  input  armCtrlPkg::dataWord   immD,
  input  logic                  flushE,
  input  armCtrlPkg::nzcvFlags  aluFlags,
  output armCtrlPkg::aluCtrl    aluControlE,
  output logic                  aluSrcE,
  output logic                  carryInE,
  output logic                  branchTakenE,
  output logic                  memtoRegE,
  output logic                  memWriteM,
  output logic                  pcWrPendingF,
  output armCtrlPkg::regNum     rdE,
  output armCtrlPkg::dataWord   immE,
  output armCtrlPkg::wbCtrl     wbW,
  output armCtrlPkg::nzcvFlags  flagsE
);

  armCtrlPkg::decodeCtrl ctrlE;
  armCtrlPkg::wbCtrl     wbM;
  logic condEx, isTestE;
  logic regWriteGatedE, memWriteGatedE, pcSrcGatedE;

  // Execute stage, flush turns the entry into a bubble
  always_ff @(posedge clk) begin
    if (reset) begin
      ctrlE <= '0;
    end else begin
      ctrlE <= ctrlD;
      if (flushE) begin
        ctrlE.flagWrite <= 2'b00;
        ctrlE.branch    <= 1'b0;
        ctrlE.memWrite  <= 1'b0;
        ctrlE.regWrite  <= 1'b0;
        ctrlE.memtoReg  <= 1'b0;
        ctrlE.pcSrc     <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    rdE  <= regsD.rd;
    immE <= immD;
  end

  condUnit i_condUnit (
    .clk      (clk),
    .reset    (reset),
    .stallE   (1'b0),
    .cond     (ctrlE.cond),
    .flagWrite(ctrlE.flagWrite),
    .aluFlags (aluFlags),
    .condEx   (condEx),
    .flags    (flagsE)
  );

  always_comb begin
    case (ctrlE.aluControl)
      `ARM_OPC_TST, `ARM_OPC_TEQ, `ARM_OPC_CMP, `ARM_OPC_CMN: isTestE = 1'b1;
      default: isTestE = 1'b0;
    endcase
  end

  // Writes and branches only take effect when the condition holds
  assign regWriteGatedE = ctrlE.regWrite & condEx & ~isTestE;
  assign memWriteGatedE = ctrlE.memWrite & condEx;
  assign pcSrcGatedE    = ctrlE.pcSrc & condEx & ~isTestE;
  assign branchTakenE   = ctrlE.branch & condEx;

  always_ff @(posedge clk) begin
    if (reset) begin
      wbM       <= '0;
      memWriteM <= 1'b0;
      wbW       <= '0;
    end else begin
      wbM.regWrite <= regWriteGatedE;
      wbM.memtoReg <= ctrlE.memtoReg;
      wbM.pcSrc    <= pcSrcGatedE;
      memWriteM    <= memWriteGatedE;
      wbW          <= wbM;
    end
  end

  assign aluControlE  = ctrlE.aluControl;
  assign aluSrcE      = ctrlE.aluSrc;
  assign memtoRegE    = ctrlE.memtoReg;
  assign carryInE     = flagsE.c;
  assign pcWrPendingF = ctrlD.pcSrc | ctrlE.pcSrc | wbM.pcSrc;  // E side not yet gated

endmodule

/* verilog/hazardUnit.sv */
`timescale 1ns/10ps

module hazardUnit (
  input  armCtrlPkg::regUse regsD,
  input  armCtrlPkg::regNum rdE,
  input  logic              memtoRegE,
  input  logic              pcWrPendingF,
  input  logic              branchTakenE,
  input  logic              pcSrcW,
  output logic              stallF,
  output logic              stallD,
  output logic              flushD,
  output logic              flushE
);

  logic ldUseHit, ldStall;

  // Load in E feeds an operand of the D instruction
  assign ldUseHit = (rdE == regsD.rn) | (rdE == regsD.rm);
  assign ldStall  = memtoRegE & ldUseHit;

  // Hold fetch until a pending PC write reaches W
  assign stallF = ldStall | pcWrPendingF;
  assign stallD = ldStall;

  assign flushD = pcWrPendingF | branchTakenE | pcSrcW;
  assign flushE = ldStall | branchTakenE;  // Bubble behind the load

endmodule

/* verilog/armCtrlPath.sv */
`timescale 1ns/10ps

module armCtrlPath (
  input  logic                 clk,
  input  logic                 reset,
  input  armCtrlPkg::instrWord instrF,
  input  armCtrlPkg::dataWord  srcA,
  input  armCtrlPkg::dataWord  srcB,
  output logic                 stallF,
  output armCtrlPkg::dataWord  resultE,
  output armCtrlPkg::nzcvFlags flagsE,
  output logic                 branchTakenE,
  output logic                 memWriteM,
  output armCtrlPkg::wbCtrl    wbW
);

  armCtrlPkg::decodeCtrl ctrlD;
  armCtrlPkg::regUse     regsD;
  armCtrlPkg::dataWord   immD, immE, srcBE;
  armCtrlPkg::aluCtrl    aluControlE;
  armCtrlPkg::regNum     rdE;
  armCtrlPkg::nzcvFlags  aluFlags;
  logic stallD, flushD, flushE;
  logic aluSrcE, carryInE, memtoRegE, pcWrPendingF;

  instrDecoder i_instrDecoder (
    .clk    (clk),
    .reset  (reset),
    .instrF (instrF),
    .stallD (stallD),
    .flushD (flushD),
    .ctrlD  (ctrlD),
    .regsD  (regsD),
    .immD   (immD),
    .immSrcD(),
    .regSrcD()
  );

  ctrlPipeline i_ctrlPipeline (
    .clk         (clk),
    .reset       (reset),
    .ctrlD       (ctrlD),
    .regsD       (regsD),
    .immD        (immD),
    .flushE      (flushE),
    .aluFlags    (aluFlags),
    .aluControlE (aluControlE),
    .aluSrcE     (aluSrcE),
    .carryInE    (carryInE),
    .branchTakenE(branchTakenE),
    .memtoRegE   (memtoRegE),
    .memWriteM   (memWriteM),
    .pcWrPendingF(pcWrPendingF),
    .rdE         (rdE),
    .immE        (immE),
    .wbW         (wbW),
    .flagsE      (flagsE)
  );

  assign srcBE = aluSrcE ? immE : srcB;  // Immediate replaces operand B

  aluCore i_aluCore (
    .srcA      (srcA),
    .srcB      (srcBE),
    .aluControl(aluControlE),
    .carryIn   (carryInE),
    .result    (resultE),
    .aluFlags  (aluFlags)
  );

  hazardUnit i_hazardUnit (
    .regsD       (regsD),
    .rdE         (rdE),
    .memtoRegE   (memtoRegE),
    .pcWrPendingF(pcWrPendingF),
    .branchTakenE(branchTakenE),
    .pcSrcW      (wbW.pcSrc),
    .stallF      (stallF),
    .stallD      (stallD),
    .flushD      (flushD),
    .flushE      (flushE)
  );

endmodule

/* tests/armCtrlPath_assert.sv */
`timescale 1ns/10ps

module armCtrlPath_assert (
  input logic              clk,
  input logic              reset,
  input logic              memWriteM,
  input armCtrlPkg::wbCtrl wbW,
  input logic              branchTakenE,
  input logic              flushD,
  input logic              stallD
);

  // Late stages come out of reset empty
  resetClear: assert property (@(posedge clk) reset |=> (!memWriteM && wbW == '0))
    else $error("memory or writeback controls active right after reset");

  // Decode stays flushed while a taken branch moves on to M
  branchFlush: assert property (@(posedge clk) disable iff (reset) branchTakenE |=> flushD)
    else $error("decode flush dropped after a taken branch");

  loadUseOnce: assert property (@(posedge clk) disable iff (reset) stallD |=> !stallD)
    else $error("load-use stall longer than one cycle");  // Only loads stall D

endmodule

bind armCtrlPath armCtrlPath_assert i_assert (
  .clk         (clk),
  .reset       (reset),
  .memWriteM   (memWriteM),
  .wbW         (wbW),
  .branchTakenE(branchTakenE),
  .flushD      (flushD),
  .stallD      (stallD)
);

/* tests/armCtrlPath_tb.sv */
`timescale 1ns/10ps
`include "arm_consts.svh"

module armCtrlPath_tb;

  localparam int cycleLimit = 2000;
  localparam armCtrlPkg::condCode condEq = 4'b0000;
  localparam armCtrlPkg::condCode condNe = 4'b0001;
  localparam armCtrlPkg::instrWord nopWord = 32'h0;

  logic clk, reset;
  armCtrlPkg::instrWord instrF;
  armCtrlPkg::dataWord srcA, srcB, opA, opB;
  logic stallF, branchTakenE, memWriteM;
  armCtrlPkg::dataWord resultE;
  armCtrlPkg::nzcvFlags flagsE;
  armCtrlPkg::wbCtrl wbW;
  int errCount, testsRun, cycleCount, seed;
  int stallCnt, regWCnt, loadWbCnt, memWCnt, takenCnt, pcSrcWCnt;

  armCtrlPath i_dut (
    .clk(clk), .reset(reset), .instrF(instrF), .srcA(srcA), .srcB(srcB),
    .stallF(stallF), .resultE(resultE), .flagsE(flagsE),
    .branchTakenE(branchTakenE), .memWriteM(memWriteM), .wbW(wbW)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= cycleLimit) begin
      $display("Run stopped: cycle limit reached before the tests finished");
      $display("ERRORS FOUND");
      $finish;
    end
  end

  function automatic armCtrlPkg::instrWord dpInstr(input armCtrlPkg::condCode cond,
      input logic immForm, input armCtrlPkg::aluCtrl opc, input logic setFlags,
      input armCtrlPkg::regNum rn, input armCtrlPkg::regNum rd, input logic [11:0] op2);
    return {cond, `ARM_OP_DP, immForm, opc, setFlags, rn, rd, op2};
  endfunction

  // Immediate offset, pre-indexed, add, word, no writeback
  function automatic armCtrlPkg::instrWord memInstr(input logic load,
      input armCtrlPkg::regNum rn, input armCtrlPkg::regNum rd, input logic [11:0] off);
    return {`ARM_COND_AL, `ARM_OP_MEM, 1'b0, 4'b1100, load, rn, rd, off};
  endfunction

  function automatic armCtrlPkg::instrWord brInstr(input armCtrlPkg::condCode cond,
      input logic [23:0] off);
    return {cond, `ARM_OP_BR, 2'b10, off};
  endfunction

  // Result in bits 31:0, NZCV on top
  function automatic logic [35:0] aluModel(input armCtrlPkg::aluCtrl opc,
      input logic [31:0] a, input logic [31:0] b);
    logic [32:0] wide;
    logic [31:0] r;
    logic c, v;
    if (opc == `ARM_OPC_ADD) begin
      wide = {1'b0, a} + {1'b0, b};
      r = wide[31:0];
      c = wide[32];
      v = (a[31] == b[31]) && (r[31] != a[31]);
    end else begin
      r = a - b;
      c = (a >= b);  // No borrow
      v = (a[31] != b[31]) && (r[31] != a[31]);
    end
    return {r[31], (r == 32'h0), c, v, r};
  endfunction

  task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
      input string what);
    if (actual !== expected) begin
      errCount++;
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic sampleOutputs();
    if (stallF) stallCnt++;
    if (wbW.regWrite) regWCnt++;
    if (wbW.memtoReg) loadWbCnt++;
    if (wbW.pcSrc) pcSrcWCnt++;
    if (memWriteM) memWCnt++;
    if (branchTakenE) begin
      takenCnt++;
      checkValue(32'(i_dut.flushD), 32'd1, "flushD during taken branch");
    end
  endtask

  task automatic clearCounts();
    stallCnt = 0;
    regWCnt = 0;
    loadWbCnt = 0;
    pcSrcWCnt = 0;
    memWCnt = 0;
    takenCnt = 0;
  endtask

  // Word is held on instrF until the fetch stall drops
  task automatic sendInstr(input armCtrlPkg::instrWord w);
    @(posedge clk);
    instrF <= w;
    srcA <= opA;
    srcB <= opB;
    @(negedge clk);
    sampleOutputs();
    while (stallF) begin
      @(negedge clk);
      sampleOutputs();
    end
  endtask

  task automatic drain(input int n);
    repeat (n) sendInstr(nopWord);
  endtask

  task automatic reportTest(input string name, input int errBefore);
    testsRun++;
    $display("%s: %s", name, (errCount == errBefore) ? "passed" : "failed");
  endtask

  task automatic resetTest();
    int errBefore;
    errBefore = errCount;
    checkValue(32'(wbW), 32'd0, "wbW after reset");
    checkValue(32'(memWriteM), 32'd0, "memWriteM after reset");
    checkValue(32'(branchTakenE), 32'd0, "branchTakenE after reset");
    checkValue(32'(stallF), 32'd0, "stallF after reset");
    checkValue(32'(i_dut.stallD), 32'd0, "stallD after reset");
    checkValue(32'(i_dut.flushD), 32'd0, "flushD after reset");
    checkValue(32'(i_dut.flushE), 32'd0, "flushE after reset");
    checkValue(32'(flagsE), 32'd0, "flags after reset");
    reportTest("reset", errBefore);
  endtask

  task automatic arithTest();
    int errBefore;
    armCtrlPkg::aluCtrl opc;
    logic [35:0] expected;
    errBefore = errCount;
    for (int i = 0; i < 8; i++) begin
      opc = (i % 2 == 1) ? `ARM_OPC_SUB : `ARM_OPC_ADD;
      opA = $random(seed);
      opB = $random(seed);
      if (i == 7) opB = opA;  // Zero result once
      expected = aluModel(opc, opA, opB);
      sendInstr(dpInstr(`ARM_COND_AL, 1'b0, opc, 1'b1, 4'd1, 4'd2, 12'd3));
      drain(2);  // Now in E
      checkValue(resultE, expected[31:0], "resultE");
      sendInstr(nopWord);
      checkValue(32'(flagsE), 32'(expected[35:32]), "flagsE");
      checkValue(32'(wbW.regWrite), 32'd0, "regWrite one cycle after E");
      sendInstr(nopWord);
      checkValue(32'(wbW.regWrite), 32'd1, "regWrite two cycles after E");
    end
    reportTest("ADDS/SUBS", errBefore);
  endtask

  task automatic condTest(input logic equal);
    int errBefore;
    errBefore = errCount;
    opA = 32'h0000_1234;
    opB = equal ? opA : 32'h0000_0042;
    clearCounts();
    sendInstr(dpInstr(`ARM_COND_AL, 1'b0, `ARM_OPC_CMP, 1'b1, 4'd1, 4'd0, 12'd2));
    sendInstr(dpInstr(condEq, 1'b0, `ARM_OPC_ADD, 1'b0, 4'd1, 4'd4, 12'd2));
    sendInstr({condEq, `ARM_OP_MEM, 1'b0, 4'b1100, 1'b0, 4'd1, 4'd3, 12'd8});
    sendInstr(dpInstr(condNe, 1'b0, `ARM_OPC_SUB, 1'b0, 4'd1, 4'd5, 12'd2));
    drain(6);
    // One of ADDEQ and SUBNE writes, CMP never does
    checkValue(32'(regWCnt), 32'd1, "register writes in W");
    checkValue(32'(memWCnt), equal ? 32'd1 : 32'd0, "memWriteM pulses");
    checkValue(32'(flagsE.z), 32'(equal), "Z after CMP");
    reportTest(equal ? "conditional, equal" : "conditional, not equal", errBefore);
  endtask

  task automatic branchTest();
    int errBefore;
    errBefore = errCount;
    opA = 32'd9;
    opB = 32'd9;
    sendInstr(dpInstr(`ARM_COND_AL, 1'b0, `ARM_OPC_CMP, 1'b1, 4'd1, 4'd0, 12'd2));
    drain(4);
    clearCounts();
    sendInstr(brInstr(`ARM_COND_AL, 24'h000010));
    drain(8);
    checkValue(32'(takenCnt), 32'd1, "taken B branchTakenE cycles");
    checkValue(32'(pcSrcWCnt), 32'd1, "taken B pcSrc in W");
    clearCounts();
    sendInstr(brInstr(condNe, 24'h000020));  // Z set, so not taken
    drain(8);
    checkValue(32'(takenCnt), 32'd0, "untaken BNE branchTakenE cycles");
    checkValue(32'(pcSrcWCnt), 32'd0, "untaken BNE pcSrc in W");
    reportTest("branch", errBefore);
  endtask

  task automatic loadUseTest();
    int errBefore;
    errBefore = errCount;
    opA = 32'h100;
    opB = 32'h4;
    clearCounts();
    sendInstr(memInstr(1'b1, 4'd1, 4'd6, 12'd4));
    sendInstr(dpInstr(`ARM_COND_AL, 1'b0, `ARM_OPC_ADD, 1'b0, 4'd6, 4'd7, 12'd2));
    drain(6);
    checkValue(32'(stallCnt), 32'd1, "stallF cycles on load-use");
    checkValue(32'(regWCnt), 32'd2, "register writes of LDR and its user");
    checkValue(32'(loadWbCnt), 32'd1, "memtoReg in W");
    reportTest("load-use", errBefore);
  endtask

  task automatic storeTest();
    int errBefore;
    errBefore = errCount;
    opA = 32'h200;
    opB = 32'h0;
    sendInstr(memInstr(1'b0, 4'd1, 4'd3, 12'd0));
    drain(3);  // STR in M
    checkValue(32'(memWriteM), 32'd1, "memWriteM in M");
    sendInstr(nopWord);
    checkValue(32'(memWriteM), 32'd0, "memWriteM after M");
    checkValue(32'(wbW.regWrite), 32'd0, "STR regWrite in W");
    drain(2);
    reportTest("store", errBefore);
  endtask

  initial begin
    seed = 34222;
    errCount = 0;
    testsRun = 0;
    cycleCount = 0;
    reset = 1'b1;
    instrF = nopWord;
    srcA = '0;
    srcB = '0;
    opA = '0;
    opB = '0;
    clearCounts();
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    resetTest();
    arithTest();
    condTest(1'b1);
    condTest(1'b0);
    branchTest();
    loadUseTest();
    storeTest();
    $display("%0d tests run, %0d checks failed", testsRun, errCount);
    if (errCount == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* armCtrlPath.f */
+incdir+.
verilog/armCtrlPkg.sv
verilog/instrDecoder.sv
verilog/condUnit.sv
verilog/aluCore.sv
verilog/ctrlPipeline.sv
verilog/hazardUnit.sv
verilog/armCtrlPath.sv
tests/armCtrlPath_assert.sv
tests/armCtrlPath_tb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f armCtrlPath.f --top-module armCtrlPath_tb -Mdir obj_dir
	@out="$$(./obj_dir/VarmCtrlPath_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
